// ==== design/ethpipe_pkg.sv ====
package ethpipe_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int HOST_DATA_W         = 16;
  localparam int SLOT_WORD_W         = 32;
  localparam int SLOT_ADDR_W_DEFAULT = 11;
  localparam int COUNTER_W           = 64;

  localparam logic [7:0] GMII_SFD = 8'hd5;

  // ------------------------------------------------------------
  // Host address map
  // ------------------------------------------------------------
  // Host address bits 15 to 13
  typedef enum logic [2:0] {
    REGION_GLOBAL = 3'd0,
    REGION_SLOT0  = 3'd4,
    REGION_SLOT1  = 3'd5,
    REGION_NONE   = 3'd7
  } host_region_e;

  // Host address bits 3 to 1 in the global region
  typedef enum logic [2:0] {
    REG_SLOT_STATUS = 3'd0,
    REG_COUNTER_0   = 3'd2,
    REG_COUNTER_1   = 3'd3,
    REG_COUNTER_2   = 3'd4,
    REG_COUNTER_3   = 3'd5
  } global_reg_e;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_PREAMBLE,
    RX_DATA,
    RX_LENGTH,
    RX_DROP
  } rx_state_e;

endpackage

// ==== design/slot_ram.sv ====
`timescale 1ns/1ps

module slot_ram #(
  parameter int SLOT_ADDR_W = ethpipe_pkg::SLOT_ADDR_W_DEFAULT
) (
  input  logic                                   clk_125,
  // Host port
  input  logic [SLOT_ADDR_W-1:0]                 addr_a_i,
  input  logic [ethpipe_pkg::SLOT_WORD_W-1:0]    data_a_i,
  input  logic [ethpipe_pkg::SLOT_WORD_W/8-1:0]  be_a_i,
  input  logic                                   we_a_i,
  output logic [ethpipe_pkg::SLOT_WORD_W-1:0]    q_a_o,
  // Receive writer port
  input  logic [SLOT_ADDR_W-1:0]                 addr_b_i,
  input  logic [ethpipe_pkg::SLOT_WORD_W-1:0]    data_b_i,
  input  logic [ethpipe_pkg::SLOT_WORD_W/8-1:0]  be_b_i,
  input  logic                                   we_b_i
);
  import ethpipe_pkg::*;

  localparam int BE_W = SLOT_WORD_W / 8;

  logic [BE_W-1:0][7:0] mem [2**SLOT_ADDR_W];

  // Host port wins a same-word collision
  always_ff @(posedge clk_125) begin
    for (int i = 0; i < BE_W; i++) begin
      if (we_b_i && be_b_i[i]) begin
        mem[addr_b_i][i] <= data_b_i[8*i +: 8];
      end
      if (we_a_i && be_a_i[i]) begin
        mem[addr_a_i][i] <= data_a_i[8*i +: 8];
      end
    end
    q_a_o <= mem[addr_a_i];
  end

endmodule

// ==== design/gmii_rx_slot_writer.sv ====
`timescale 1ns/1ps

module gmii_rx_slot_writer #(
  parameter int SLOT_ADDR_W = ethpipe_pkg::SLOT_ADDR_W_DEFAULT
) (
  input  logic                                   clk_125,
  input  logic                                   core_rst_n,
  input  logic [7:0]                             rxd_i,
  input  logic                                   rx_dv_i,
  input  logic                                   released_i,
  output logic [SLOT_ADDR_W-1:0]                 ram_addr_o,
  output logic [ethpipe_pkg::SLOT_WORD_W-1:0]    ram_data_o,
  output logic [ethpipe_pkg::SLOT_WORD_W/8-1:0]  ram_be_o,
  output logic                                   ram_we_o,
  output logic                                   frame_done_o
);
  import ethpipe_pkg::*;

  localparam int CNT_W = SLOT_ADDR_W + 2;
  localparam int BE_W  = SLOT_WORD_W / 8;
  // Word 0 holds the length, so one word less for data
  localparam logic [CNT_W-1:0] MAX_BYTES = CNT_W'((2**SLOT_ADDR_W - 1) * 4);

  rx_state_e              state;
  logic [CNT_W-1:0]       byte_cnt;
  logic [23:0]            word_buf;
  logic [1:0]             lane;
  logic [SLOT_ADDR_W-1:0] data_addr;
  logic                   full;

  logic                   wr_en;
  logic [SLOT_ADDR_W-1:0] wr_addr;
  logic [SLOT_WORD_W-1:0] wr_data;
  logic [BE_W-1:0]        wr_be;

  assign lane      = byte_cnt[1:0];
  assign data_addr = byte_cnt[CNT_W-1:2] + 1'b1;
  assign full      = (byte_cnt == MAX_BYTES);

  // ------------------------------------------------------------
  // Next slot write
  // ------------------------------------------------------------
  always_comb begin
    wr_en   = 1'b0;
    wr_addr = data_addr;
    wr_data = {rxd_i, word_buf};
    wr_be   = '1;
    case (state)
      RX_DATA: begin
        if (rx_dv_i) begin
          wr_en = !full && (lane == 2'd3);
        end else begin
          // Flush of a partial last word
          wr_en   = (lane != 2'd0);
          wr_data = {8'h00, word_buf};
          wr_be   = BE_W'((1 << lane) - 1);
        end
      end
      RX_LENGTH: begin
        wr_en   = 1'b1;
        wr_addr = '0;
        wr_data = SLOT_WORD_W'(byte_cnt);
      end
      default: begin
        wr_en = 1'b0;
      end
    endcase
  end

  // ------------------------------------------------------------
  // Frame FSM
  // ------------------------------------------------------------
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      state        <= RX_IDLE;
      byte_cnt     <= '0;
      ram_we_o     <= 1'b0;
      frame_done_o <= 1'b0;
    end else begin
      ram_we_o     <= wr_en;
      frame_done_o <= 1'b0;
      case (state)
        RX_IDLE, RX_PREAMBLE: begin
          if (rx_dv_i && rxd_i == GMII_SFD) begin
            byte_cnt <= '0;
            state    <= released_i ? RX_DATA : RX_DROP;
          end else begin
            state <= rx_dv_i ? RX_PREAMBLE : RX_IDLE;
          end
        end
        RX_DATA: begin
          if (!rx_dv_i) begin
            state <= RX_LENGTH;
          end else if (!full) begin
            byte_cnt <= byte_cnt + 1'b1;
          end
        end
        RX_LENGTH: begin
          frame_done_o <= 1'b1;
          state        <= RX_IDLE;
        end
        RX_DROP: begin
          if (!rx_dv_i) begin
            state <= RX_IDLE;
          end
        end
        default: begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

  // Little-endian byte packing
  always_ff @(posedge clk_125) begin
    if (state == RX_DATA && rx_dv_i && !full && lane != 2'd3) begin
      word_buf[lane*8 +: 8] <= rxd_i;
    end
    ram_addr_o <= wr_addr;
    ram_data_o <= wr_data;
    ram_be_o   <= wr_be;
  end

endmodule

// ==== design/slot_host_port.sv ====
`timescale 1ns/1ps

module slot_host_port #(
  parameter int SLOT_ADDR_W = ethpipe_pkg::SLOT_ADDR_W_DEFAULT
) (
  input  logic                                   clk_125,
  input  logic                                   core_rst_n,
  input  logic                                   req_i,
  input  logic                                   req_we_i,
  input  logic [15:0]                            req_adr_i,
  input  logic [1:0]                             req_sel_i,
  input  logic [ethpipe_pkg::HOST_DATA_W-1:0]    req_dat_i,
  input  logic [ethpipe_pkg::SLOT_WORD_W-1:0]    ram_q_i,
  output logic [ethpipe_pkg::HOST_DATA_W-1:0]    dat_o,
  output logic                                   done_o,
  output logic [SLOT_ADDR_W-1:0]                 ram_addr_o,
  output logic [ethpipe_pkg::SLOT_WORD_W-1:0]    ram_data_o,
  output logic [ethpipe_pkg::SLOT_WORD_W/8-1:0]  ram_be_o,
  output logic                                   ram_we_o
);

  logic       rd_addr_q;
  logic       rd_ram_q;
  logic       rd_cap_q;
  logic       half_q;
  logic [1:0] be_lanes;

  // sel[1] enables the low byte and sel[0] the high byte
  assign be_lanes = {req_sel_i[0], req_sel_i[1]};

  // Writes complete at once and reads after address, RAM and capture
  assign done_o = (req_i && req_we_i) || rd_cap_q;

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      rd_addr_q <= 1'b0;
      rd_ram_q  <= 1'b0;
      rd_cap_q  <= 1'b0;
      ram_we_o  <= 1'b0;
    end else begin
      rd_addr_q <= req_i && !req_we_i;
      rd_ram_q  <= rd_addr_q;
      rd_cap_q  <= rd_ram_q;
      ram_we_o  <= req_i && req_we_i;
    end
  end

  always_ff @(posedge clk_125) begin
    if (req_i) begin
      ram_addr_o <= req_adr_i[SLOT_ADDR_W+1:2];
      half_q     <= req_adr_i[1];
      ram_data_o <= {2{req_dat_i}};
      ram_be_o   <= req_adr_i[1] ? {be_lanes, 2'b00} : {2'b00, be_lanes};
    end
    if (rd_ram_q) begin
      dat_o <= half_q ? ram_q_i[31:16] : ram_q_i[15:0];
    end
  end

endmodule

// ==== design/slot_status_regs.sv ====
`timescale 1ns/1ps

module slot_status_regs (
  input  logic                                 clk_125,
  input  logic                                 core_rst_n,
  input  logic                                 req_i,
  input  logic                                 req_we_i,
  input  logic [15:0]                          req_adr_i,
  input  logic [1:0]                           req_sel_i,
  input  logic [ethpipe_pkg::HOST_DATA_W-1:0]  req_dat_i,
  input  logic                                 frame_done0_i,
  input  logic                                 frame_done1_i,
  output logic [ethpipe_pkg::HOST_DATA_W-1:0]  dat_o,
  output logic                                 done_o,
  output logic                                 released0_o,
  output logic                                 released1_o,
  output logic                                 inta_n_o
);
  import ethpipe_pkg::*;

  logic [3:0]           status_q;
  logic [3:0]           status_d;
  logic [COUNTER_W-1:0] counter_q;
  logic                 reg_page;
  global_reg_e          reg_sel;

  // Registers live only in the first 16 bytes
  assign reg_page = (req_adr_i[12:4] == '0);
  assign reg_sel  = global_reg_e'(req_adr_i[3:1]);
  assign done_o   = req_i;

  assign released0_o = status_q[1];
  assign released1_o = status_q[3];
  assign inta_n_o    = !(status_q[0] || status_q[2]);

  // A finished frame overrides a host write in the same cycle
  always_comb begin
    status_d = status_q;
    if (req_i && req_we_i && req_sel_i[1] && reg_page && reg_sel == REG_SLOT_STATUS) begin
      status_d = req_dat_i[3:0];
    end
    if (frame_done0_i) begin
      status_d[1:0] = 2'b01;
    end
    if (frame_done1_i) begin
      status_d[3:2] = 2'b01;
    end
  end

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      status_q  <= '0;
      counter_q <= '0;
    end else begin
      status_q  <= status_d;
      counter_q <= counter_q + 1'b1;
    end
  end

  always_comb begin
    dat_o = '0;
    if (reg_page) begin
      case (reg_sel)
        REG_SLOT_STATUS: dat_o = {{(HOST_DATA_W-4){1'b0}}, status_q};
        REG_COUNTER_0:   dat_o = counter_q[0*HOST_DATA_W +: HOST_DATA_W];
        REG_COUNTER_1:   dat_o = counter_q[1*HOST_DATA_W +: HOST_DATA_W];
        REG_COUNTER_2:   dat_o = counter_q[2*HOST_DATA_W +: HOST_DATA_W];
        REG_COUNTER_3:   dat_o = counter_q[3*HOST_DATA_W +: HOST_DATA_W];
        default:         dat_o = '0;
      endcase
    end
  end

endmodule

// ==== design/host_bus_slave.sv ====
`timescale 1ns/1ps

module host_bus_slave (
  input  logic                                 clk_125,
  input  logic                                 core_rst_n,
  input  logic [15:0]                          wb_adr_i,
  input  logic [ethpipe_pkg::HOST_DATA_W-1:0]  wb_dat_i,
  input  logic [1:0]                           wb_sel_i,
  input  logic                                 wb_we_i,
  input  logic                                 wb_cyc_i,
  input  logic                                 wb_stb_i,
  input  logic [ethpipe_pkg::HOST_DATA_W-1:0]  status_dat_i,
  input  logic                                 status_done_i,
  input  logic [ethpipe_pkg::HOST_DATA_W-1:0]  slot0_dat_i,
  input  logic                                 slot0_done_i,
  input  logic [ethpipe_pkg::HOST_DATA_W-1:0]  slot1_dat_i,
  input  logic                                 slot1_done_i,
  output logic [ethpipe_pkg::HOST_DATA_W-1:0]  wb_dat_o,
  output logic                                 wb_ack_o,
  output logic                                 status_req_o,
  output logic                                 slot0_req_o,
  output logic                                 slot1_req_o,
  output logic                                 req_we_o,
  output logic [15:0]                          req_adr_o,
  output logic [1:0]                           req_sel_o,
  output logic [ethpipe_pkg::HOST_DATA_W-1:0]  req_dat_o
);
  import ethpipe_pkg::*;

  host_region_e           region;
  logic                   bus_req;
  logic                   served_q;
  logic                   none_req;
  logic [HOST_DATA_W-1:0] rd_mux;

  always_comb begin
    case (wb_adr_i[15:13])
      3'd0:    region = REGION_GLOBAL;
      3'd4:    region = REGION_SLOT0;
      3'd5:    region = REGION_SLOT1;
      default: region = REGION_NONE;
    endcase
  end

  // One request per bus cycle and none again until stb drops
  assign bus_req      = wb_cyc_i && wb_stb_i && !served_q;
  assign status_req_o = bus_req && (region == REGION_GLOBAL);
  assign slot0_req_o  = bus_req && (region == REGION_SLOT0);
  assign slot1_req_o  = bus_req && (region == REGION_SLOT1);
  assign none_req     = bus_req && (region == REGION_NONE);

  assign req_we_o  = wb_we_i;
  assign req_adr_o = wb_adr_i;
  assign req_sel_o = wb_sel_i;
  assign req_dat_o = wb_dat_i;

  // Unmapped region falls through to zero
  always_comb begin
    rd_mux = '0;
    if (status_done_i) begin
      rd_mux = status_dat_i;
    end else if (slot0_done_i) begin
      rd_mux = slot0_dat_i;
    end else if (slot1_done_i) begin
      rd_mux = slot1_dat_i;
    end
  end

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      served_q <= 1'b0;
      wb_ack_o <= 1'b0;
    end else begin
      if (!(wb_cyc_i && wb_stb_i)) begin
        served_q <= 1'b0;
      end else if (bus_req) begin
        served_q <= 1'b1;
      end
      wb_ack_o <= status_done_i || slot0_done_i || slot1_done_i || none_req;
    end
  end

  always_ff @(posedge clk_125) begin
    wb_dat_o <= rd_mux;
  end

endmodule

// ==== design/ethpipe_top.sv ====
`timescale 1ns/1ps

module ethpipe_top #(
  parameter int SLOT_ADDR_W = ethpipe_pkg::SLOT_ADDR_W_DEFAULT
) (
  input  logic                                 clk_125,
  input  logic                                 core_rst_n,
  input  logic [15:0]                          wb_adr_i,
  input  logic [ethpipe_pkg::HOST_DATA_W-1:0]  wb_dat_i,
  output logic [ethpipe_pkg::HOST_DATA_W-1:0]  wb_dat_o,
  input  logic [1:0]                           wb_sel_i,
  input  logic                                 wb_we_i,
  input  logic                                 wb_cyc_i,
  input  logic                                 wb_stb_i,
  output logic                                 wb_ack_o,
  input  logic [7:0]                           gmii0_rxd_i,
  input  logic                                 gmii0_rx_dv_i,
  input  logic [7:0]                           gmii1_rxd_i,
  input  logic                                 gmii1_rx_dv_i,
  output logic                                 inta_n_o
);
  import ethpipe_pkg::*;

  logic                   status_req;
  logic                   status_done;
  logic [HOST_DATA_W-1:0] status_dat;
  logic                   req_we;
  logic [15:0]            req_adr;
  logic [1:0]             req_sel;
  logic [HOST_DATA_W-1:0] req_dat;

  logic [1:0]             slot_req;
  logic [1:0]             slot_done;
  logic [HOST_DATA_W-1:0] slot_dat [2];
  logic [1:0]             released;
  logic [1:0]             frame_done;

  host_bus_slave u_bus (
    .clk_125(clk_125), .core_rst_n(core_rst_n),
    .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
    .wb_we_i(wb_we_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
    .status_dat_i(status_dat), .status_done_i(status_done),
    .slot0_dat_i(slot_dat[0]), .slot0_done_i(slot_done[0]),
    .slot1_dat_i(slot_dat[1]), .slot1_done_i(slot_done[1]),
    .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .status_req_o(status_req), .slot0_req_o(slot_req[0]), .slot1_req_o(slot_req[1]),
    .req_we_o(req_we), .req_adr_o(req_adr), .req_sel_o(req_sel), .req_dat_o(req_dat)
  );

  slot_status_regs u_status (
    .clk_125(clk_125), .core_rst_n(core_rst_n),
    .req_i(status_req), .req_we_i(req_we), .req_adr_i(req_adr),
    .req_sel_i(req_sel), .req_dat_i(req_dat),
    .frame_done0_i(frame_done[0]), .frame_done1_i(frame_done[1]),
    .dat_o(status_dat), .done_o(status_done),
    .released0_o(released[0]), .released1_o(released[1]), .inta_n_o(inta_n_o)
  );

  // ------------------------------------------------------------
  // One receive channel per slot
  // ------------------------------------------------------------
  for (genvar ch = 0; ch < 2; ch++) begin : g_chan
    logic [SLOT_ADDR_W-1:0]   host_addr;
    logic [SLOT_WORD_W-1:0]   host_data;
    logic [SLOT_WORD_W/8-1:0] host_be;
    logic                     host_we;
    logic [SLOT_WORD_W-1:0]   host_q;
    logic [SLOT_ADDR_W-1:0]   rx_addr;
    logic [SLOT_WORD_W-1:0]   rx_data;
    logic [SLOT_WORD_W/8-1:0] rx_be;
    logic                     rx_we;

    slot_host_port #(.SLOT_ADDR_W(SLOT_ADDR_W)) u_port (
      .clk_125(clk_125), .core_rst_n(core_rst_n),
      .req_i(slot_req[ch]), .req_we_i(req_we), .req_adr_i(req_adr),
      .req_sel_i(req_sel), .req_dat_i(req_dat), .ram_q_i(host_q),
      .dat_o(slot_dat[ch]), .done_o(slot_done[ch]),
      .ram_addr_o(host_addr), .ram_data_o(host_data), .ram_be_o(host_be), .ram_we_o(host_we)
    );

    slot_ram #(.SLOT_ADDR_W(SLOT_ADDR_W)) u_ram (
      .clk_125(clk_125),
      .addr_a_i(host_addr), .data_a_i(host_data), .be_a_i(host_be), .we_a_i(host_we),
      .q_a_o(host_q),
      .addr_b_i(rx_addr), .data_b_i(rx_data), .be_b_i(rx_be), .we_b_i(rx_we)
    );

    gmii_rx_slot_writer #(.SLOT_ADDR_W(SLOT_ADDR_W)) u_writer (
      .clk_125(clk_125), .core_rst_n(core_rst_n),
      .rxd_i(ch == 0 ? gmii0_rxd_i : gmii1_rxd_i),
      .rx_dv_i(ch == 0 ? gmii0_rx_dv_i : gmii1_rx_dv_i),
      .released_i(released[ch]),
      .ram_addr_o(rx_addr), .ram_data_o(rx_data), .ram_be_o(rx_be), .ram_we_o(rx_we),
      .frame_done_o(frame_done[ch])
    );
  end

endmodule

// ==== verification/ethpipe_tb.sv ====
`timescale 1ns/1ps

module ethpipe_tb;
  import ethpipe_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 10;
  localparam int ACK_TIMEOUT  = 16;
  localparam int IRQ_TIMEOUT  = 16;
  localparam int PREAMBLE_LEN = 7;
  localparam int FRAME0_LEN   = 61;
  localparam int FRAME1_LEN   = 24;
  localparam int DROP_LEN     = 20;
  localparam int BUS_ACCESSES = 150;
  // Every access and frame at its worst case and then doubled
  localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + BUS_ACCESSES * (ACK_TIMEOUT + 2)
      + FRAME0_LEN + FRAME1_LEN + DROP_LEN + 3 * (PREAMBLE_LEN + 2 + IRQ_TIMEOUT));

  logic        clk_125;
  logic        core_rst_n;
  logic [15:0] wb_adr;
  logic [15:0] wb_dat_wr;
  logic [15:0] wb_dat_rd;
  logic [1:0]  wb_sel;
  logic        wb_we;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_ack;
  logic [7:0]  gmii0_rxd;
  logic        gmii0_rx_dv;
  logic [7:0]  gmii1_rxd;
  logic        gmii1_rx_dv;
  logic        inta_n;

  // Expected slot contents, with a valid bit per byte
  logic [31:0] exp_mem [2][32];
  logic [3:0]  exp_vld [2][32];
  logic [7:0]  frame_q [$];
  integer      seed;
  int          err_cnt;
  int          err_base;
  int          check_cnt;
  int          tests_run;
  string       cur_test;

  ethpipe_top #(.SLOT_ADDR_W(SLOT_ADDR_W_DEFAULT)) dut_i (
    .clk_125(clk_125), .core_rst_n(core_rst_n),
    .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_wr), .wb_dat_o(wb_dat_rd), .wb_sel_i(wb_sel),
    .wb_we_i(wb_we), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_ack_o(wb_ack),
    .gmii0_rxd_i(gmii0_rxd), .gmii0_rx_dv_i(gmii0_rx_dv),
    .gmii1_rxd_i(gmii1_rxd), .gmii1_rx_dv_i(gmii1_rx_dv), .inta_n_o(inta_n)
  );

  initial clk_125 = 1'b0;
  always #(CLK_PERIOD / 2) clk_125 = ~clk_125;

  // ------------------------------------------------------------
  // Checking and reference model
  // ------------------------------------------------------------
  task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
    check_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("CHECK FAILED %s: expected %h, actual %h", cur_test, expected, actual);
    end
  endtask

  function automatic logic [15:0] slot_addr(input int slot, input int word, input int half);
    logic [15:0] base;
    base = (slot == 0) ? 16'h8000 : 16'ha000;
    return base | 16'(word * 4 + half * 2);
  endfunction

  // sel[1] carries data bits 7:0 and sel[0] bits 15:8
  function automatic void model_host_write(input int slot, input int word, input int half,
                                           input logic [1:0] sel, input logic [15:0] dat);
    if (sel[1]) begin
      exp_mem[slot][word][16*half +: 8] = dat[7:0];
      exp_vld[slot][word][2*half] = 1'b1;
    end
    if (sel[0]) begin
      exp_mem[slot][word][16*half+8 +: 8] = dat[15:8];
      exp_vld[slot][word][2*half+1] = 1'b1;
    end
  endfunction

  // Length in word 0 and bytes little-endian from word 1
  function automatic void model_frame(input int slot);
    int len;
    len = frame_q.size();
    exp_mem[slot][0] = 32'(len);
    exp_vld[slot][0] = 4'hf;
    for (int i = 0; i < len; i++) begin
      exp_mem[slot][1 + i/4][8*(i%4) +: 8] = frame_q[i];
      exp_vld[slot][1 + i/4][i%4] = 1'b1;
    end
  endfunction

  // ------------------------------------------------------------
  // Bus and GMII drivers
  // ------------------------------------------------------------
  task automatic bus_access(input logic we, input logic [15:0] adr, input logic [1:0] sel,
                            input logic [15:0] wdat, output logic [15:0] rdat);
    int   n;
    logic ack_seen;
    wb_adr    = adr;
    wb_sel    = sel;
    wb_dat_wr = wdat;
    wb_we     = we;
    wb_cyc    = 1'b1;
    wb_stb    = 1'b1;
    n         = 0;
    ack_seen  = 1'b0;
    while (!ack_seen && n < ACK_TIMEOUT) begin
      @(posedge clk_125);
      #1;
      n++;
      ack_seen = wb_ack;
    end
    rdat   = wb_dat_rd;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (!ack_seen) begin
      err_cnt++;
      $display("%s: bus access to address %h got no acknowledge", cur_test, adr);
    end
    @(posedge clk_125);
    #1;
  endtask

  task automatic bus_read(input logic [15:0] adr, output logic [15:0] rdat);
    bus_access(1'b0, adr, 2'b11, 16'h0000, rdat);
  endtask

  task automatic bus_write(input logic [15:0] adr, input logic [1:0] sel,
                           input logic [15:0] dat);
    logic [15:0] unused;
    bus_access(1'b1, adr, sel, dat, unused);
  endtask

  task automatic drive_gmii(input int port, input logic dv, input logic [7:0] data);
    if (port == 0) begin
      gmii0_rx_dv = dv;
      gmii0_rxd   = data;
    end else begin
      gmii1_rx_dv = dv;
      gmii1_rxd   = data;
    end
    @(posedge clk_125);
    #1;
  endtask

  task automatic send_frame(input int port, input int len);
    logic [31:0] r;
    frame_q.delete();
    for (int i = 0; i < PREAMBLE_LEN; i++) begin
      drive_gmii(port, 1'b1, 8'h55);
    end
    drive_gmii(port, 1'b1, GMII_SFD);
    for (int i = 0; i < len; i++) begin
      r = $random(seed);
      frame_q.push_back(r[7:0]);
      drive_gmii(port, 1'b1, r[7:0]);
    end
    drive_gmii(port, 1'b0, 8'h00);
  endtask

  task automatic wait_irq();
    int n;
    n = 0;
    while (inta_n !== 1'b0 && n < IRQ_TIMEOUT) begin
      @(posedge clk_125);
      #1;
      n++;
    end
    if (inta_n !== 1'b0) begin
      err_cnt++;
      $display("%s: interrupt did not assert after the frame", cur_test);
    end
  endtask

  // Bytes never written are masked out of the compare
  task automatic check_slot_word(input int slot, input int word);
    logic [15:0] rd;
    logic [15:0] mask;
    for (int h = 0; h < 2; h++) begin
      bus_read(slot_addr(slot, word, h), rd);
      mask = {{8{exp_vld[slot][word][2*h+1]}}, {8{exp_vld[slot][word][2*h]}}};
      check_value(32'(exp_mem[slot][word][16*h +: 16] & mask), 32'(rd & mask));
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_base = err_cnt;
  endtask

  task automatic end_test();
    tests_run++;
    $display("%s: %s, %0d mismatches", cur_test, (err_cnt == err_base) ? "ok" : "errors",
             err_cnt - err_base);
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic test_reset();
    logic [15:0] rd;
    start_test("reset_state");
    check_value(32'h0, 32'(wb_ack));
    check_value(32'h1, 32'(inta_n));
    bus_read(16'h0000, rd);
    check_value(32'h0, 32'(rd));
    end_test();
  endtask

  task automatic test_global_regs();
    logic [15:0] lo;
    logic [15:0] hi;
    logic [31:0] first;
    logic [31:0] second;
    start_test("global_regs");
    bus_read(16'h0004, lo);
    bus_read(16'h0006, hi);
    first = {hi, lo};
    bus_read(16'h0004, lo);
    bus_read(16'h0006, hi);
    second = {hi, lo};
    check_value(32'h1, 32'(second > first));
    bus_write(16'h0002, 2'b11, 16'hffff);
    bus_read(16'h0002, lo);
    check_value(32'h0, 32'(lo));
    bus_read(16'h000c, lo);
    check_value(32'h0, 32'(lo));
    bus_write(16'h2000, 2'b11, 16'hffff);
    bus_read(16'h2000, lo);
    check_value(32'h0, 32'(lo));
    bus_read(16'he000, lo);
    check_value(32'h0, 32'(lo));
    end_test();
  endtask

  task automatic test_slot_access();
    logic [1:0]  sel_pat [3];
    logic [31:0] r;
    int          h;
    start_test("slot_access");
    sel_pat = '{2'b10, 2'b01, 2'b00};
    for (int s = 0; s < 2; s++) begin
      for (int w = 0; w < 3; w++) begin
        for (int hh = 0; hh < 2; hh++) begin
          r = $random(seed);
          bus_write(slot_addr(s, w, hh), 2'b11, r[15:0]);
          model_host_write(s, w, hh, 2'b11, r[15:0]);
        end
        for (int p = 0; p < 3; p++) begin
          h = (w + p) % 2;
          r = $random(seed);
          bus_write(slot_addr(s, w, h), sel_pat[p], r[15:0]);
          model_host_write(s, w, h, sel_pat[p], r[15:0]);
        end
        check_slot_word(s, w);
      end
    end
    end_test();
  endtask

  task automatic test_dropped_frame();
    logic [15:0] rd;
    start_test("dropped_frame");
    send_frame(1, DROP_LEN);
    repeat (4) @(posedge clk_125);
    #1;
    check_value(32'h1, 32'(inta_n));
    bus_read(16'h0000, rd);
    check_value(32'h0, 32'(rd));
    for (int w = 0; w < 3; w++) begin
      check_slot_word(1, w);
    end
    end_test();
  endtask

  task automatic test_frame_capture();
    logic [15:0] rd;
    start_test("frame_capture");
    bus_write(16'h0000, 2'b11, 16'h0002);
    send_frame(0, FRAME0_LEN);
    wait_irq();
    bus_read(16'h0000, rd);
    check_value(32'h1, 32'(rd));
    model_frame(0);
    for (int w = 0; w <= (FRAME0_LEN + 3) / 4; w++) begin
      check_slot_word(0, w);
    end
    end_test();
  endtask

  task automatic test_irq_clear();
    logic [15:0] rd;
    start_test("irq_clear");
    bus_write(16'h0000, 2'b11, 16'h0000);
    check_value(32'h1, 32'(inta_n));
    bus_write(16'h0000, 2'b11, 16'h0008);
    send_frame(1, FRAME1_LEN);
    wait_irq();
    bus_read(16'h0000, rd);
    check_value(32'h4, 32'(rd));
    model_frame(1);
    for (int w = 0; w <= (FRAME1_LEN + 3) / 4; w++) begin
      check_slot_word(1, w);
    end
    end_test();
  endtask

  initial begin
    seed        = 32'h0d8f_5191;
    err_cnt     = 0;
    err_base    = 0;
    check_cnt   = 0;
    tests_run   = 0;
    cur_test    = "init";
    core_rst_n  = 1'b0;
    wb_adr      = '0;
    wb_dat_wr   = '0;
    wb_sel      = '0;
    wb_we       = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    gmii0_rxd   = '0;
    gmii0_rx_dv = 1'b0;
    gmii1_rxd   = '0;
    gmii1_rx_dv = 1'b0;
    for (int s = 0; s < 2; s++) begin
      for (int w = 0; w < 32; w++) begin
        exp_mem[s][w] = '0;
        exp_vld[s][w] = '0;
      end
    end
    repeat (RESET_CYCLES) @(posedge clk_125);
    #1;
    core_rst_n = 1'b1;
    @(posedge clk_125);
    #1;
    test_reset();
    test_global_regs();
    test_slot_access();
    // Both slots still owned by the host here
    test_dropped_frame();
    test_frame_capture();
    test_irq_clear();
    $display("tests %0d, checks %0d, mismatches %0d", tests_run, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_125);
    $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== project.f ====
design/ethpipe_pkg.sv
design/slot_ram.sv
design/gmii_rx_slot_writer.sv
design/slot_host_port.sv
design/slot_status_regs.sv
design/host_bus_slave.sv
design/ethpipe_top.sv
verification/ethpipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator, from the project root
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  --top-module ethpipe_tb \
  -f project.f \
  --Mdir obj_dir -o ethpipe_sim

./obj_dir/ethpipe_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
  exit 0
else
  exit 1
fi
